// File: compile.f
source/clint_pkg.sv
source/clint_axi_slave.sv
source/clint_regs.sv
source/clint_top.sv
sim/clint_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the clint testbench with verilator, run it, and judge the result from the log

log=sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module clint_tb -o clint_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/clint_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q ">>> FAIL" "$log"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if ! grep -q ">>> PASS" "$log"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// File: sim/clint_tb.sv
// clint testbench: clock, reset, axi driver tasks, checker, lfsr, watchdog and test sequence
`timescale 1ns/1ps
`default_nettype none

module clint_tb;

  localparam int unsigned mtime_div   = 4;
  localparam int          max_entries = 64;
  localparam int          fields      = 6;

  localparam logic [3:0] op_write = 4'h0;
  localparam logic [3:0] op_read  = 4'h1;
  localparam logic [3:0] op_irq   = 4'h2;
  localparam logic [3:0] op_mtime = 4'h3;
  localparam logic [3:0] op_burst = 4'h4;
  localparam logic [3:0] op_end   = 4'hF;

  logic        clk = 1'b0;
  logic        rst;
  logic        aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i;
  logic [63:0] aw_addr_i, ar_addr_i, w_data_i, r_data_o;
  logic [3:0]  aw_id_i, ar_id_i, b_id_o, r_id_o;
  logic        aw_user_i, ar_user_i, b_user_o, r_user_o;
  logic [7:0]  w_strb_i;
  logic        b_valid_o, b_ready_i, ar_valid_i, ar_ready_o;
  logic        r_valid_o, r_ready_i, r_last_o;
  logic [1:0]  b_resp_o, r_resp_o;
  logic        soft_irq_o, timer_irq_o;

  logic [63:0] tdata [0:max_entries*fields-1];
  int          n_entries = 0;
  longint      cycle_cnt = 0;
  longint      last_w_cycle = 0;
  logic [15:0] lfsr_state = 16'd48;

  clint_top #(
    .mtime_div (mtime_div)
  ) clint_top_inst (
    .clk (clk), .rst (rst),
    .aw_valid_i (aw_valid_i), .aw_ready_o (aw_ready_o), .aw_addr_i (aw_addr_i),
    .aw_id_i (aw_id_i), .aw_user_i (aw_user_i),
    .w_valid_i (w_valid_i), .w_ready_o (w_ready_o), .w_data_i (w_data_i),
    .w_strb_i (w_strb_i), .w_last_i (w_last_i),
    .b_valid_o (b_valid_o), .b_ready_i (b_ready_i), .b_resp_o (b_resp_o),
    .b_id_o (b_id_o), .b_user_o (b_user_o),
    .ar_valid_i (ar_valid_i), .ar_ready_o (ar_ready_o), .ar_addr_i (ar_addr_i),
    .ar_id_i (ar_id_i), .ar_user_i (ar_user_i),
    .r_valid_o (r_valid_o), .r_ready_i (r_ready_i), .r_data_o (r_data_o),
    .r_resp_o (r_resp_o), .r_last_o (r_last_o), .r_id_o (r_id_o), .r_user_o (r_user_o),
    .soft_irq_o (soft_irq_o), .timer_irq_o (timer_irq_o)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      report_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  // 16-bit galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int k = 0; k < n; k++) begin
      v = (v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic axi_write(input logic [63:0] addr, input logic [63:0] data,
                           input logic [7:0] strb, input int beats, input logic [3:0] id,
                           output logic [1:0] resp, output logic [3:0] bid, output logic buser);
    int d;
    aw_valid_i = 1'b1;
    aw_addr_i  = addr;
    aw_id_i    = id;
    aw_user_i  = id[0];
    while (!aw_ready_o) @(negedge clk);
    @(negedge clk);
    aw_valid_i = 1'b0;
    for (int k = 0; k < beats; k++) begin
      w_valid_i = 1'b1;
      w_data_i  = data + 64'(k);
      w_strb_i  = strb;
      w_last_i  = (k == beats - 1);
      while (!w_ready_o) @(negedge clk);
      @(negedge clk);
      last_w_cycle = cycle_cnt;
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
    while (!b_valid_o) @(negedge clk);
    take_bits(2, d);
    repeat (d) @(negedge clk);
    b_ready_i = 1'b1;
    resp  = b_resp_o;
    bid   = b_id_o;
    buser = b_user_o;
    @(negedge clk);
    b_ready_i = 1'b0;
  endtask

  task automatic axi_read(input logic [63:0] addr, input logic [3:0] id,
                          output logic [63:0] data, output logic [1:0] resp,
                          output logic [3:0] rid, output logic ruser, output logic rlast,
                          output longint r_cycle);
    int d;
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    ar_id_i    = id;
    ar_user_i  = id[0];
    while (!ar_ready_o) @(negedge clk);
    @(negedge clk);
    ar_valid_i = 1'b0;
    while (!r_valid_o) @(negedge clk);
    take_bits(2, d);
    repeat (d) @(negedge clk);
    r_ready_i = 1'b1;
    data    = r_data_o;
    resp    = r_resp_o;
    rid     = r_id_o;
    ruser   = r_user_o;
    rlast   = r_last_o;
    r_cycle = cycle_cnt;
    @(negedge clk);
    r_ready_i = 1'b0;
  endtask

  // generous budget per access on top of reset and start-up
  initial begin
    wait (n_entries > 0);
    repeat (n_entries * 200 + 2000) @(posedge clk);
    report_failure("watchdog expired, the simulation hung");
  end

  initial begin
    int          cnt;
    logic [3:0]  op;
    logic [63:0] addr, data, expv, rdata, hi;
    logic [7:0]  strb;
    logic [1:0]  exp_resp, resp;
    logic [3:0]  id, rid;
    logic        ruser, rlast;
    longint      r_cycle;
    string       name;

    rst = 1'b1;
    aw_valid_i = 1'b0;
    aw_addr_i = '0;
    aw_id_i = '0;
    aw_user_i = 1'b0;
    w_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    w_last_i = 1'b0;
    b_ready_i = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i = '0;
    ar_id_i = '0;
    ar_user_i = 1'b0;
    r_ready_i = 1'b0;

    $readmemh("sim/clint_testdata.txt", tdata);
    cnt = 0;
    while (cnt < max_entries && tdata[cnt*fields] != 64'(op_end)) cnt++;
    if (cnt == 0 || cnt == max_entries) begin
      report_failure("testdata file is missing or has no end marker");
    end
    n_entries = cnt;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // idle after reset: aw_ready and ar_ready high, w_ready, b_valid and r_valid low
    check_eq("reset {aw_ready,w_ready,b_valid,ar_ready,r_valid}", 64'h12,
             64'({aw_ready_o, w_ready_o, b_valid_o, ar_ready_o, r_valid_o}));

    for (int i = 0; i < n_entries; i++) begin
      op       = tdata[i*fields][3:0];
      addr     = tdata[i*fields+1];
      data     = tdata[i*fields+2];
      strb     = tdata[i*fields+3][7:0];
      exp_resp = tdata[i*fields+4][1:0];
      expv     = tdata[i*fields+5];
      id       = 4'(i);
      name     = $sformatf("entry %0d", i);
      case (op)
        op_write, op_burst: begin
          axi_write(addr, data, strb, (op == op_burst) ? 3 : 1, id, resp, rid, ruser);
          check_eq({name, " b_resp"}, 64'(exp_resp), 64'(resp));
          check_eq({name, " b_id"}, 64'(id), 64'(rid));
          check_eq({name, " b_user"}, 64'(id[0]), 64'(ruser));
          // one b response per burst, then back to idle
          check_eq({name, " {w_ready,b_valid} after b"}, 64'd0,
                   64'({w_ready_o, b_valid_o}));
        end
        op_read, op_mtime: begin
          axi_read(addr, id, rdata, resp, rid, ruser, rlast, r_cycle);
          check_eq({name, " r_resp"}, 64'(exp_resp), 64'(resp));
          check_eq({name, " r_id"}, 64'(id), 64'(rid));
          check_eq({name, " r_user"}, 64'(id[0]), 64'(ruser));
          check_eq({name, " r_last"}, 64'd1, 64'(rlast));
          check_eq({name, " r_valid after r"}, 64'd0, 64'(r_valid_o));
          if (op == op_read) begin
            check_eq({name, " r_data"}, expv, rdata);
          end else begin
            // mtime may have ticked since it was written
            hi = expv + 64'((r_cycle - last_w_cycle) / mtime_div) + 64'd1;
            check_eq($sformatf("%s mtime %h within [%h,%h]", name, rdata, expv, hi),
                     64'd1, 64'(rdata >= expv && rdata <= hi));
          end
        end
        op_irq: begin
          check_eq({name, " {soft_irq,timer_irq}"}, expv, {62'd0, soft_irq_o, timer_irq_o});
        end
        default: begin
          report_failure($sformatf("testdata entry %0d has an unknown operation", i));
        end
      endcase
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/clint_testdata.txt
// op addr data strb resp expect; op 0 write, 1 read, 2 irq {soft,timer}, 3 mtime range, 4 burst of 3
// op 3 expects a value from expect up to the ticks since the last write, F ends the list
2 0 0 0 0 1
1 02000000 0 0 0 0
1 02004000 0 0 0 0
3 0200BFF8 0 0 0 0
0 02004000 1122334455667788 FF 0 0
1 02004000 0 0 0 1122334455667788
0 02004000 AABBCCDDEEFF0011 0F 0 0
1 02004000 0 0 0 11223344EEFF0011
0 02004000 9999999999999999 A5 0 0
1 02004000 0 0 0 99229944EE990099
0 02000000 FFFFFFFFFFFFFFFF FF 0 0
2 0 0 0 0 2
1 02000000 0 0 0 1
0 02000000 0 01 0 0
2 0 0 0 0 0
1 02000000 0 0 0 0
0 0200BFF8 0000000000000100 FF 0 0
3 0200BFF8 0 0 0 0000000000000100
0 02004000 FFFFFFFFFFFF0000 FF 0 0
2 0 0 0 0 0
0 02004000 0000000000000010 FF 0 0
2 0 0 0 0 1
0 02000008 DEADBEEFDEADBEEF FF 2 0
1 02000008 0 0 2 0
0 02014000 5555555555555555 FF 2 0
1 02014000 0 0 2 0
0 01004000 7777777777777777 FF 2 0
1 02004000 0 0 0 0000000000000010
4 02004000 0000000100000000 FF 0 0
1 02004000 0 0 0 0000000100000002
2 0 0 0 0 0
F 0 0 0 0 0

// File: source/clint_axi_slave.sv
// axi4 slave front end for the clint: read and write fsms, request capture, register strobes
`timescale 1ns/1ps
`default_nettype none

module clint_axi_slave #(
  parameter int unsigned       addr_w    = 64,
  parameter int unsigned       id_w      = 4,
  parameter int unsigned       user_w    = 1,
  parameter logic [addr_w-1:0] base_addr = 'h0200_0000
) (
  input  wire                                 clk,
  input  wire                                 rst,

  // aw channel
  input  wire                                 aw_valid_i,
  output logic                                aw_ready_o,
  input  wire  [addr_w-1:0]                   aw_addr_i,
  input  wire  [id_w-1:0]                     aw_id_i,
  input  wire  [user_w-1:0]                   aw_user_i,

  // w channel
  input  wire                                 w_valid_i,
  output logic                                w_ready_o,
  input  wire  [clint_pkg::clint_data_w-1:0]  w_data_i,
  input  wire  [clint_pkg::clint_strb_w-1:0]  w_strb_i,
  input  wire                                 w_last_i,

  // b channel
  output logic                                b_valid_o,
  input  wire                                 b_ready_i,
  output logic [1:0]                          b_resp_o,
  output logic [id_w-1:0]                     b_id_o,
  output logic [user_w-1:0]                   b_user_o,

  // ar channel
  input  wire                                 ar_valid_i,
  output logic                                ar_ready_o,
  input  wire  [addr_w-1:0]                   ar_addr_i,
  input  wire  [id_w-1:0]                     ar_id_i,
  input  wire  [user_w-1:0]                   ar_user_i,

  // r channel
  output logic                                r_valid_o,
  input  wire                                 r_ready_i,
  output logic [clint_pkg::clint_data_w-1:0]  r_data_o,
  output logic [1:0]                          r_resp_o,
  output logic                                r_last_o,
  output logic [id_w-1:0]                     r_id_o,
  output logic [user_w-1:0]                   r_user_o,

  // register block side
  output logic                                wr_en_o,
  output logic [clint_pkg::clint_off_w-1:0]   wr_off_o,
  output logic [clint_pkg::clint_data_w-1:0]  wr_data_o,
  output logic [clint_pkg::clint_strb_w-1:0]  wr_strb_o,
  output logic [clint_pkg::clint_off_w-1:0]   rd_off_o,
  input  wire  [clint_pkg::clint_data_w-1:0]  rd_data_i,
  input  wire                                 rd_hit_i,
  input  wire                                 wr_hit_i
);

  import clint_pkg::*;

  typedef enum logic {
    rd_idle,
    rd_data
  } rd_state_e;

  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_resp
  } wr_state_e;

  rd_state_e rd_state_q;
  wr_state_e wr_state_q;

  logic                    ar_hs;
  logic                    r_hs;
  logic                    aw_hs;
  logic                    w_hs;
  logic                    b_hs;

  logic [clint_off_w-1:0]  rd_off_q;
  logic [id_w-1:0]         rd_id_q;
  logic [user_w-1:0]       rd_user_q;
  logic                    r_valid_q;
  logic [clint_data_w-1:0] r_data_q;
  logic [1:0]              r_resp_q;

  logic [clint_off_w-1:0]  wr_off_q;
  logic [id_w-1:0]         wr_id_q;
  logic [user_w-1:0]       wr_user_q;
  logic                    wr_miss_q;
  logic [1:0]              b_resp_q;

  // outside the 64 KiB window the offset becomes all ones, which hits nothing
  function automatic logic [clint_off_w-1:0] addr_to_off(input logic [addr_w-1:0] addr);
    logic [addr_w-1:0] rel;
    rel = addr - base_addr;
    if (rel[addr_w-1:clint_off_w] != '0) begin
      return '1;
    end
    return rel[clint_off_w-1:0];
  endfunction

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign b_hs  = b_valid_o && b_ready_i;

  // read side
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state_q <= rd_idle;
      r_valid_q  <= 1'b0;
    end else begin
      case (rd_state_q)
        rd_idle: begin
          if (ar_hs) begin
            rd_state_q <= rd_data;
          end
        end
        rd_data: begin
          // first cycle samples the register, then waits for r_ready
          if (!r_valid_q) begin
            r_valid_q <= 1'b1;
          end else if (r_hs) begin
            r_valid_q  <= 1'b0;
            rd_state_q <= rd_idle;
          end
        end
        default: rd_state_q <= rd_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_off_q  <= addr_to_off(ar_addr_i);
      rd_id_q   <= ar_id_i;
      rd_user_q <= ar_user_i;
    end
    if (rd_state_q == rd_data && !r_valid_q) begin
      r_data_q <= rd_data_i;
      r_resp_q <= rd_hit_i ? resp_okay : resp_slverr;
    end
  end

  assign ar_ready_o = (rd_state_q == rd_idle);
  assign r_valid_o  = r_valid_q;
  assign r_data_o   = r_data_q;
  assign r_resp_o   = r_resp_q;
  assign r_last_o   = r_valid_q;
  assign r_id_o     = rd_id_q;
  assign r_user_o   = rd_user_q;
  assign rd_off_o   = rd_off_q;

  // write side
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state_q <= wr_idle;
      wr_miss_q  <= 1'b0;
    end else begin
      case (wr_state_q)
        wr_idle: begin
          if (aw_hs) begin
            wr_state_q <= wr_data;
            wr_miss_q  <= 1'b0;
          end
        end
        wr_data: begin
          if (w_hs) begin
            wr_miss_q <= wr_miss_q | ~wr_hit_i;
            if (w_last_i) begin
              wr_state_q <= wr_resp;
            end
          end
        end
        wr_resp: begin
          if (b_hs) begin
            wr_state_q <= wr_idle;
          end
        end
        default: wr_state_q <= wr_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_off_q  <= addr_to_off(aw_addr_i);
      wr_id_q   <= aw_id_i;
      wr_user_q <= aw_user_i;
    end
    // any missed beat in the burst turns the response into slverr
    if (w_hs && w_last_i) begin
      b_resp_q <= (wr_miss_q || !wr_hit_i) ? resp_slverr : resp_okay;
    end
  end

  assign aw_ready_o = (wr_state_q == wr_idle);
  assign w_ready_o  = (wr_state_q == wr_data);
  assign b_valid_o  = (wr_state_q == wr_resp);
  assign b_resp_o   = b_resp_q;
  assign b_id_o     = wr_id_q;
  assign b_user_o   = wr_user_q;

  // each w beat is a single-cycle write strobe
  assign wr_en_o   = w_hs;
  assign wr_off_o  = wr_off_q;
  assign wr_data_o = w_data_i;
  assign wr_strb_o = w_strb_i;

endmodule

`default_nettype wire

// File: source/clint_pkg.sv
// clint register offsets, bus widths, axi response codes and register select enum
`default_nettype none

package clint_pkg;

  // registers and bus are both 64 bits wide
  localparam int unsigned clint_data_w = 64;
  localparam int unsigned clint_strb_w = clint_data_w / 8;

  // 64 KiB window behind the base address
  localparam int unsigned clint_off_w = 16;

  localparam logic [clint_off_w-1:0] off_msip     = 16'h0000;
  localparam logic [clint_off_w-1:0] off_mtimecmp = 16'h4000;
  localparam logic [clint_off_w-1:0] off_mtime    = 16'hBFF8;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef enum logic [1:0] {
    sel_none,
    sel_msip,
    sel_mtimecmp,
    sel_mtime
  } reg_sel_e;

endpackage

`default_nettype wire

// File: source/clint_regs.sv
// clint register block: offset decode, byte-strobed writes, mtime divider and counter, irqs
`timescale 1ns/1ps
`default_nettype none

module clint_regs #(
  parameter int unsigned mtime_div = 1
) (
  input  wire                                 clk,
  input  wire                                 rst,

  input  wire                                 wr_en_i,
  input  wire  [clint_pkg::clint_off_w-1:0]   wr_off_i,
  input  wire  [clint_pkg::clint_data_w-1:0]  wr_data_i,
  input  wire  [clint_pkg::clint_strb_w-1:0]  wr_strb_i,
  input  wire  [clint_pkg::clint_off_w-1:0]   rd_off_i,

  output logic [clint_pkg::clint_data_w-1:0]  rd_data_o,
  output logic                                rd_hit_o,
  output logic                                wr_hit_o,

  output logic                                soft_irq_o,
  output logic                                timer_irq_o
);

  import clint_pkg::*;

  localparam int unsigned div_w = (mtime_div > 1) ? $clog2(mtime_div) : 1;

  reg_sel_e                wr_sel;
  reg_sel_e                rd_sel;
  logic [clint_data_w-1:0] wr_mask;
  logic                    wr_msip;
  logic                    wr_mtimecmp;
  logic                    wr_mtime;

  logic                    msip_q;
  logic [clint_data_w-1:0] mtimecmp_q;
  logic [clint_data_w-1:0] mtime_q;
  logic [div_w-1:0]        tick_cnt_q;
  logic                    tick;

  function automatic reg_sel_e decode(input logic [clint_off_w-1:0] off);
    case (off)
      off_msip:     return sel_msip;
      off_mtimecmp: return sel_mtimecmp;
      off_mtime:    return sel_mtime;
      default:      return sel_none;
    endcase
  endfunction

  assign wr_sel   = decode(wr_off_i);
  assign rd_sel   = decode(rd_off_i);
  assign wr_hit_o = (wr_sel != sel_none);
  assign rd_hit_o = (rd_sel != sel_none);

  // expand byte strobes into a bit mask
  always_comb begin
    for (int i = 0; i < clint_strb_w; i++) begin
      wr_mask[i*8 +: 8] = {8{wr_strb_i[i]}};
    end
  end

  assign wr_msip     = wr_en_i && (wr_sel == sel_msip);
  assign wr_mtimecmp = wr_en_i && (wr_sel == sel_mtimecmp);
  assign wr_mtime    = wr_en_i && (wr_sel == sel_mtime);

  // only bit 0 of msip exists
  always_ff @(posedge clk) begin
    if (rst) begin
      msip_q <= 1'b0;
    end else if (wr_msip && wr_strb_i[0]) begin
      msip_q <= wr_data_i[0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp_q <= '0;
    end else if (wr_mtimecmp) begin
      mtimecmp_q <= (mtimecmp_q & ~wr_mask) | (wr_data_i & wr_mask);
    end
  end

  // timebase divider, one tick every mtime_div cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      tick_cnt_q <= '0;
    end else if (tick) begin
      tick_cnt_q <= '0;
    end else begin
      tick_cnt_q <= tick_cnt_q + 1'b1;
    end
  end

  assign tick = (tick_cnt_q == div_w'(mtime_div - 1));

  // a write to mtime wins over the tick
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= '0;
    end else if (wr_mtime) begin
      mtime_q <= (mtime_q & ~wr_mask) | (wr_data_i & wr_mask);
    end else if (tick) begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  always_comb begin
    case (rd_sel)
      sel_msip:     rd_data_o = clint_data_w'(msip_q);
      sel_mtimecmp: rd_data_o = mtimecmp_q;
      sel_mtime:    rd_data_o = mtime_q;
      default:      rd_data_o = '0;
    endcase
  end

  assign soft_irq_o  = msip_q;
  assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

`default_nettype wire

// File: source/clint_top.sv
// clint top level joining the axi4 slave front end and the register block
`timescale 1ns/1ps
`default_nettype none

module clint_top #(
  parameter int unsigned       addr_w    = 64,
  parameter int unsigned       id_w      = 4,
  parameter int unsigned       user_w    = 1,
  parameter logic [addr_w-1:0] base_addr = 'h0200_0000,
  parameter int unsigned       mtime_div = 1
) (
  input  wire                                 clk,
  input  wire                                 rst,

  input  wire                                 aw_valid_i,
  output logic                                aw_ready_o,
  input  wire  [addr_w-1:0]                   aw_addr_i,
  input  wire  [id_w-1:0]                     aw_id_i,
  input  wire  [user_w-1:0]                   aw_user_i,

  input  wire                                 w_valid_i,
  output logic                                w_ready_o,
  input  wire  [clint_pkg::clint_data_w-1:0]  w_data_i,
  input  wire  [clint_pkg::clint_strb_w-1:0]  w_strb_i,
  input  wire                                 w_last_i,

  output logic                                b_valid_o,
  input  wire                                 b_ready_i,
  output logic [1:0]                          b_resp_o,
  output logic [id_w-1:0]                     b_id_o,
  output logic [user_w-1:0]                   b_user_o,

  input  wire                                 ar_valid_i,
  output logic                                ar_ready_o,
  input  wire  [addr_w-1:0]                   ar_addr_i,
  input  wire  [id_w-1:0]                     ar_id_i,
  input  wire  [user_w-1:0]                   ar_user_i,

  output logic                                r_valid_o,
  input  wire                                 r_ready_i,
  output logic [clint_pkg::clint_data_w-1:0]  r_data_o,
  output logic [1:0]                          r_resp_o,
  output logic                                r_last_o,
  output logic [id_w-1:0]                     r_id_o,
  output logic [user_w-1:0]                   r_user_o,

  // level interrupts to the core
  output logic                                soft_irq_o,
  output logic                                timer_irq_o
);

  import clint_pkg::*;

  logic                    wr_en;
  logic [clint_off_w-1:0]  wr_off;
  logic [clint_data_w-1:0] wr_data;
  logic [clint_strb_w-1:0] wr_strb;
  logic [clint_off_w-1:0]  rd_off;
  logic [clint_data_w-1:0] rd_data;
  logic                    rd_hit;
  logic                    wr_hit;

  clint_axi_slave #(
    .addr_w    (addr_w),
    .id_w      (id_w),
    .user_w    (user_w),
    .base_addr (base_addr)
  ) axi_slave_inst (
    .clk        (clk),
    .rst        (rst),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_addr_i  (aw_addr_i),
    .aw_id_i    (aw_id_i),
    .aw_user_i  (aw_user_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_last_i   (w_last_i),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_resp_o   (b_resp_o),
    .b_id_o     (b_id_o),
    .b_user_o   (b_user_o),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_addr_i  (ar_addr_i),
    .ar_id_i    (ar_id_i),
    .ar_user_i  (ar_user_i),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_last_o   (r_last_o),
    .r_id_o     (r_id_o),
    .r_user_o   (r_user_o),
    .wr_en_o    (wr_en),
    .wr_off_o   (wr_off),
    .wr_data_o  (wr_data),
    .wr_strb_o  (wr_strb),
    .rd_off_o   (rd_off),
    .rd_data_i  (rd_data),
    .rd_hit_i   (rd_hit),
    .wr_hit_i   (wr_hit)
  );

  clint_regs #(
    .mtime_div (mtime_div)
  ) regs_inst (
    .clk         (clk),
    .rst         (rst),
    .wr_en_i     (wr_en),
    .wr_off_i    (wr_off),
    .wr_data_i   (wr_data),
    .wr_strb_i   (wr_strb),
    .rd_off_i    (rd_off),
    .rd_data_o   (rd_data),
    .rd_hit_o    (rd_hit),
    .wr_hit_o    (wr_hit),
    .soft_irq_o  (soft_irq_o),
    .timer_irq_o (timer_irq_o)
  );

endmodule

`default_nettype wire
